// ==== include/servo_settings.svh ====
// width, coefficient scaling, firmware version and command address macros
`ifndef SERVO_SETTINGS_SVH
`define SERVO_SETTINGS_SVH

//////////////////////////////////////////////////
// sample path widths
//////////////////////////////////////////////////
// raw ADC sample
`define SERVO_ADC_SIZE 16
// filtered channel
`define SERVO_SIGNAL_SIZE 24
// filter sum, wide enough for three products
`define SERVO_ACC_SIZE 48
// filter coefficients, two integer bits
`define SERVO_COEF_SIZE 18
`define SERVO_COEF_FRAC 16
// front-end gain field per channel
`define SERVO_GAIN_SIZE 2

//////////////////////////////////////////////////
// command port
//////////////////////////////////////////////////
`define SERVO_ADDR_SIZE 16
`define SERVO_RSP_SIZE 16
`define SERVO_FW_VERSION 16'h0012
`define SERVO_ADDR_VERSION 16'd0
`define SERVO_ADDR_ADC0 16'd1
`define SERVO_ADDR_ADC1 16'd2
`define SERVO_ADDR_DIFF 16'd3
`define SERVO_ADDR_GAIN 16'd4
`endif

// ==== hdl/servo_sig_pkg.sv ====
// sample, signal, coefficient, filter setup, channel setup and DAC word types
`include "servo_settings.svh"

package servo_sig_pkg;

	//////////////////////////////////////////////////
	// sample path values
	//////////////////////////////////////////////////
	// straight from the ADC
	typedef logic signed [`SERVO_ADC_SIZE-1:0] adc_sample_t;
	// after the low-pass, 8 extra fraction bits
	typedef logic signed [`SERVO_SIGNAL_SIZE-1:0] signal_t;
	// fixed point, COEF_FRAC fraction bits
	typedef logic signed [`SERVO_COEF_SIZE-1:0] coef_t;
	// code for the fast DAC, top of a signal
	typedef logic [15:0] dac_word_t;

	//////////////////////////////////////////////////
	// per-channel configuration
	//////////////////////////////////////////////////
	// first-order section
	// y = b0*u + b1*u_prev + a1*y_prev
	typedef struct packed {
		logic on;
		coef_t a1;
		coef_t b0;
		coef_t b1;
	} iir_cfg_t;

	// filter plus front-end gain field
	typedef struct packed {
		iir_cfg_t iir;
		logic [`SERVO_GAIN_SIZE-1:0] gain;
	} chan_cfg_t;

endpackage

// ==== hdl/servo_cmd_pkg.sv ====
// command opcode enum, decoded request and reply structs
`include "servo_settings.svh"

package servo_cmd_pkg;

	//////////////////////////////////////////////////
	// opcodes
	//////////////////////////////////////////////////
	// one per readable address, OP_BAD for the rest
	typedef enum logic [2:0] {
		OP_VERSION = 3'd0,
		OP_ADC0 = 3'd1,
		OP_ADC1 = 3'd2,
		OP_DIFF = 3'd3,
		OP_GAIN = 3'd4,
		OP_BAD = 3'd5
	} cmd_op_e;

	// decoded command, valid for one cycle
	typedef struct packed {
		logic valid;
		cmd_op_e op;
	} cmd_req_t;

	// reply, no back-pressure
	// err set only for an unknown address
	typedef struct packed {
		logic valid;
		logic err;
		logic [`SERVO_RSP_SIZE-1:0] data;
	} cmd_rsp_t;

endpackage

// ==== hdl/cmd_decode.sv ====
// command strobe register and address to opcode decoder
`timescale 1ns/1ns
`include "servo_settings.svh"

module cmd_decode (
	input  logic clk1,
	input  logic i_rst,
	input  logic i_cmd_trig,
	input  logic [`SERVO_ADDR_SIZE-1:0] i_cmd_addr,
	output servo_cmd_pkg::cmd_req_t o_req
);
	import servo_cmd_pkg::*;

	// opcode for the address on the port now
	cmd_op_e op_next;

	//////////////////////////////////////////////////
	// address map
	//////////////////////////////////////////////////
	always_comb begin
		case (i_cmd_addr)
			`SERVO_ADDR_VERSION: op_next = OP_VERSION;
			`SERVO_ADDR_ADC0: op_next = OP_ADC0;
			`SERVO_ADDR_ADC1: op_next = OP_ADC1;
			`SERVO_ADDR_DIFF: op_next = OP_DIFF;
			`SERVO_ADDR_GAIN: op_next = OP_GAIN;
			// everything else is answered with err
			default: op_next = OP_BAD;
		endcase
	end

	//////////////////////////////////////////////////
	// request register
	//////////////////////////////////////////////////
	always_ff @(posedge clk1) begin
		if (i_rst) begin
			o_req.valid <= 1'b0;
			o_req.op <= OP_BAD;
		end else begin
			// valid follows the strobe one cycle later
			o_req.valid <= i_cmd_trig;
			// opcode only moves on a strobe
			if (i_cmd_trig) begin
				o_req.op <= op_next;
			end
		end
	end

	// an isolated strobe gives an isolated request
	a_req_one_cycle: assert property (@(posedge clk1) disable iff (i_rst)
		(i_cmd_trig ##1 !i_cmd_trig) |-> (o_req.valid ##1 !o_req.valid));

endmodule

// ==== hdl/iir_first_order.sv ====
// first-order IIR low-pass filter with bypass, one channel
`timescale 1ns/1ns
`include "servo_settings.svh"

module iir_first_order (
	input  logic clk1,
	input  logic i_rst,
	input  servo_sig_pkg::iir_cfg_t i_cfg,
	input  servo_sig_pkg::adc_sample_t i_x,
	output servo_sig_pkg::signal_t o_y
);
	import servo_sig_pkg::*;

	// sample moved up to signal scale
	signal_t u;
	// filter memory
	signal_t x_prev;
	signal_t y_prev;
	// sum of products and the rescaled sum
	logic signed [`SERVO_ACC_SIZE-1:0] acc;
	logic signed [`SERVO_ACC_SIZE-1:0] acc_sh;
	signal_t y_next;

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////
	// low bits zero, sample sits in the top 16
	assign u = {i_x, {(`SERVO_SIGNAL_SIZE - `SERVO_ADC_SIZE){1'b0}}};

	// all operands signed, sign-extended to the sum width
	assign acc = i_cfg.b0 * u + i_cfg.b1 * x_prev + i_cfg.a1 * y_prev;

	// drop the coefficient fraction
	assign acc_sh = acc >>> `SERVO_COEF_FRAC;

	// keep the low signal bits, overflow wraps
	assign y_next = acc_sh[`SERVO_SIGNAL_SIZE-1:0];

	//////////////////////////////////////////////////
	// state and output register
	//////////////////////////////////////////////////
	always_ff @(posedge clk1) begin
		if (i_rst) begin
			x_prev <= '0;
			y_prev <= '0;
			o_y <= '0;
		end else if (i_cfg.on) begin
			// filtering
			x_prev <= u;
			y_prev <= y_next;
			o_y <= y_next;
		end else begin
			// bypass, memory starts from zero when switched on
			x_prev <= '0;
			y_prev <= '0;
			o_y <= u;
		end
	end

	// bypass passes the sample straight through one register
	a_bypass: assert property (@(posedge clk1) disable iff (i_rst)
		!i_cfg.on |=> (o_y == $past(u)));

endmodule

// ==== hdl/servo_result.sv ====
// channel difference, DAC words, front-end gain codes and command reply
`timescale 1ns/1ns
`include "servo_settings.svh"

module servo_result (
	input  logic clk1,
	input  logic i_rst,
	input  servo_cmd_pkg::cmd_req_t i_req,
	input  servo_sig_pkg::signal_t i_y0,
	input  servo_sig_pkg::signal_t i_y1,
	input  servo_sig_pkg::adc_sample_t i_raw0,
	input  servo_sig_pkg::adc_sample_t i_raw1,
	input  logic [2*`SERVO_GAIN_SIZE-1:0] i_gain,
	output servo_cmd_pkg::cmd_rsp_t o_rsp,
	output servo_sig_pkg::dac_word_t o_dac0,
	output servo_sig_pkg::dac_word_t o_dac1,
	output servo_sig_pkg::signal_t o_diff,
	output logic [2*`SERVO_GAIN_SIZE-1:0] o_afe_gain
);
	import servo_sig_pkg::*;
	import servo_cmd_pkg::*;

	// largest gain field, front-end code runs the other way
	localparam logic [`SERVO_GAIN_SIZE-1:0] GAIN_MAX = '1;
	localparam int DAC_SIZE = $bits(dac_word_t);

	cmd_rsp_t rsp_next;

	//////////////////////////////////////////////////
	// reply mux
	//////////////////////////////////////////////////
	always_comb begin
		rsp_next = '0;
		rsp_next.valid = i_req.valid;
		if (i_req.valid) begin
			case (i_req.op)
				OP_VERSION: rsp_next.data = `SERVO_FW_VERSION;
				OP_ADC0: rsp_next.data = i_raw0;
				OP_ADC1: rsp_next.data = i_raw1;
				// difference as it stands before this edge
				OP_DIFF: rsp_next.data = o_diff[`SERVO_SIGNAL_SIZE-1 -: `SERVO_RSP_SIZE];
				OP_GAIN: rsp_next.data[2*`SERVO_GAIN_SIZE-1:0] = i_gain;
				// OP_BAD, zero data
				default: rsp_next.err = 1'b1;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk1) begin
		if (i_rst) begin
			o_rsp <= '0;
			o_dac0 <= '0;
			o_dac1 <= '0;
			o_diff <= '0;
			o_afe_gain <= '0;
		end else begin
			o_rsp <= rsp_next;
			// top of each channel to the fast DAC
			o_dac0 <= i_y0[`SERVO_SIGNAL_SIZE-1 -: DAC_SIZE];
			o_dac1 <= i_y1[`SERVO_SIGNAL_SIZE-1 -: DAC_SIZE];
			// wraps at signal width
			o_diff <= i_y0 - i_y1;
			// channel 1 in the upper field
			o_afe_gain[`SERVO_GAIN_SIZE-1:0] <= GAIN_MAX - i_gain[`SERVO_GAIN_SIZE-1:0];
			o_afe_gain[2*`SERVO_GAIN_SIZE-1:`SERVO_GAIN_SIZE] <=
				GAIN_MAX - i_gain[2*`SERVO_GAIN_SIZE-1:`SERVO_GAIN_SIZE];
		end
	end

	// err only on a reply to an unknown address
	a_err_bad_only: assert property (@(posedge clk1) disable iff (i_rst)
		o_rsp.err |-> (o_rsp.valid && $past(i_req.op == OP_BAD)));

endmodule

// ==== hdl/servo_top.sv ====
// servo signal path top, input and configuration registers and instances
`timescale 1ns/1ns
`include "servo_settings.svh"

module servo_top (
	input  logic clk1,
	input  logic i_rst,
	input  logic i_cmd_trig,
	input  logic [`SERVO_ADDR_SIZE-1:0] i_cmd_addr,
	input  servo_sig_pkg::adc_sample_t i_adc0,
	input  servo_sig_pkg::adc_sample_t i_adc1,
	input  servo_sig_pkg::chan_cfg_t i_cfg0,
	input  servo_sig_pkg::chan_cfg_t i_cfg1,
	output servo_cmd_pkg::cmd_rsp_t o_rsp,
	output servo_sig_pkg::dac_word_t o_dac0,
	output servo_sig_pkg::dac_word_t o_dac1,
	output servo_sig_pkg::signal_t o_diff,
	output logic [2*`SERVO_GAIN_SIZE-1:0] o_afe_gain
);
	import servo_sig_pkg::*;
	import servo_cmd_pkg::*;

	// registered samples and setup
	adc_sample_t adc_q0;
	adc_sample_t adc_q1;
	chan_cfg_t cfg_q0;
	chan_cfg_t cfg_q1;
	// filtered channels
	signal_t y0;
	signal_t y1;
	cmd_req_t req;

	//////////////////////////////////////////////////
	// input and configuration registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk1) begin
		adc_q0 <= i_adc0;
		adc_q1 <= i_adc1;
		cfg_q0 <= i_cfg0;
		cfg_q1 <= i_cfg1;
	end

	//////////////////////////////////////////////////
	// command decode, filters, result stage
	//////////////////////////////////////////////////
	cmd_decode u_cmd_decode (.clk1(clk1), .i_rst(i_rst), .i_cmd_trig(i_cmd_trig),
		.i_cmd_addr(i_cmd_addr), .o_req(req));

	iir_first_order u_iir0 (.clk1(clk1), .i_rst(i_rst), .i_cfg(cfg_q0.iir),
		.i_x(adc_q0), .o_y(y0));

	iir_first_order u_iir1 (.clk1(clk1), .i_rst(i_rst), .i_cfg(cfg_q1.iir),
		.i_x(adc_q1), .o_y(y1));

	// gain fields packed with channel 1 on top
	servo_result u_servo_result (.clk1(clk1), .i_rst(i_rst), .i_req(req),
		.i_y0(y0), .i_y1(y1), .i_raw0(adc_q0), .i_raw1(adc_q1),
		.i_gain({cfg_q1.gain, cfg_q0.gain}), .o_rsp(o_rsp), .o_dac0(o_dac0),
		.o_dac1(o_dac1), .o_diff(o_diff), .o_afe_gain(o_afe_gain));

endmodule

// ==== verification/tb_clock.sv ====
// testbench clock source and power-on reset
`timescale 1ns/1ns

module tb_clock (
	output logic o_clk1,
	output logic o_rst
);
	// 40 ns period
	initial begin
		o_clk1 = 1'b0;
		forever #20 o_clk1 = ~o_clk1;
	end

	// reset held for 16 rising edges, released off the edge
	initial begin
		o_rst = 1'b1;
		repeat (16) @(posedge o_clk1);
		#5 o_rst = 1'b0;
	end

endmodule

// ==== verification/tb_servo_top.sv ====
// directed tests, filter reference model, compare tasks and watchdog for servo_top
`timescale 1ns/1ns
`include "servo_settings.svh"

module tb_servo_top;
	import servo_sig_pkg::*;
	import servo_cmd_pkg::*;

	// reset, two streams, four gain reads, command burst, last step
	localparam int TEST_CYCLES = 16 + (40 + 3) + (30 + 3) + 4 * (1 + 2) + (6 + 2) + 1;

	logic clk1, i_rst, i_cmd_trig;
	logic [`SERVO_ADDR_SIZE-1:0] i_cmd_addr;
	adc_sample_t i_adc0, i_adc1;
	chan_cfg_t i_cfg0, i_cfg1;
	cmd_rsp_t o_rsp;
	dac_word_t o_dac0, o_dac1;
	signal_t o_diff;
	logic [2*`SERVO_GAIN_SIZE-1:0] o_afe_gain;
	integer seed = 32'he3e9_b6e8;
	// stimulus and expected values per step
	adc_sample_t xs0 [64], xs1 [64];
	signal_t exp_y0 [64], exp_y1 [64];
	logic [`SERVO_ADDR_SIZE-1:0] cmd_addr [8];
	adc_sample_t cmd_adc [8];
	cmd_rsp_t exp_rsp [8];
	// model filter memory per channel
	signal_t up [2], yp [2];

	tb_clock u_tb_clock (.o_clk1(clk1), .o_rst(i_rst));

	servo_top u_servo_top (.clk1(clk1), .i_rst(i_rst), .i_cmd_trig(i_cmd_trig),
		.i_cmd_addr(i_cmd_addr), .i_adc0(i_adc0), .i_adc1(i_adc1), .i_cfg0(i_cfg0),
		.i_cfg1(i_cfg1), .o_rsp(o_rsp), .o_dac0(o_dac0), .o_dac1(o_dac1),
		.o_diff(o_diff), .o_afe_gain(o_afe_gain));

	task automatic fail_stop();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_signal(string name, signal_t exp, signal_t act);
		if (exp !== act) begin
			$display("Error %s expected %h got %h", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_dac(string name, dac_word_t exp, dac_word_t act);
		if (exp !== act) begin
			$display("Error %s expected %h got %h", name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_rsp(cmd_rsp_t exp, cmd_rsp_t act);
		if (exp !== act) begin
			$display("Error o_rsp expected %h got %h", exp, act);
			fail_stop();
		end
	endtask

	task automatic check_gain(logic [2*`SERVO_GAIN_SIZE-1:0] exp,
		logic [2*`SERVO_GAIN_SIZE-1:0] act);
		if (exp !== act) begin
			$display("Error o_afe_gain expected %h got %h", exp, act);
			fail_stop();
		end
	endtask

	// first-order section by its equation y = (b0*u + b1*u1 + a1*y1) >>> frac
	function automatic signal_t model_iir(int ch, iir_cfg_t cfg, adc_sample_t x);
		signal_t u;
		longint acc;
		u = {x, 8'h00};
		if (!cfg.on) begin
			up[ch] = '0;
			yp[ch] = '0;
			return u;
		end
		acc = longint'(cfg.b0) * longint'(u) + longint'(cfg.b1) * longint'(up[ch])
			+ longint'(cfg.a1) * longint'(yp[ch]);
		acc = acc >>> `SERVO_COEF_FRAC;
		up[ch] = u;
		yp[ch] = acc[`SERVO_SIGNAL_SIZE-1:0];
		return yp[ch];
	endfunction

	// one clock with inputs moved a little after the edge
	task automatic step();
		@(posedge clk1);
		#5;
	endtask

	// sample stream checked three edges after each drive
	task automatic run_stream(int n);
		for (int j = 0; j < n + 3; j++) begin
			step();
			if (j >= 3) begin
				check_dac("o_dac0", exp_y0[j-3][23:8], o_dac0);
				check_dac("o_dac1", exp_y1[j-3][23:8], o_dac1);
				check_signal("o_diff", exp_y0[j-3] - exp_y1[j-3], o_diff);
			end
			if (j < n) begin
				i_adc0 = xs0[j];
				i_adc1 = xs1[j];
				exp_y0[j] = model_iir(0, i_cfg0.iir, xs0[j]);
				exp_y1[j] = model_iir(1, i_cfg1.iir, xs1[j]);
			end
		end
	endtask

	// strobes on consecutive cycles with each reply due two edges later
	task automatic run_cmds(int n);
		for (int k = 0; k < n + 2; k++) begin
			step();
			if (k < 2 && o_rsp.valid) begin
				$display("reply came before its command could be decoded");
				fail_stop();
			end
			if (k >= 2 && !o_rsp.valid) begin
				$display("command %0d got no reply two cycles after its strobe", k - 2);
				fail_stop();
			end
			if (k >= 2)
				check_rsp(exp_rsp[k-2], o_rsp);
			i_cmd_trig = (k < n);
			if (k < n) begin
				i_cmd_addr = cmd_addr[k];
				i_adc0 = cmd_adc[k];
				i_adc1 = ~cmd_adc[k];
			end
		end
		i_cmd_trig = 1'b0;
	endtask

	// watchdog sized from the test length
	initial begin
		#(40 * (TEST_CYCLES + 200));
		$display("simulation timed out before the tests finished");
		fail_stop();
	end

	initial begin
		i_cmd_trig = 1'b0;
		i_cmd_addr = '0;
		i_adc0 = '0;
		i_adc1 = '0;
		i_cfg0 = '0;
		i_cfg1 = '0;
		@(negedge i_rst);
		// reset values
		check_rsp('0, o_rsp);
		check_signal("o_diff", '0, o_diff);
		check_dac("o_dac0", '0, o_dac0);
		check_dac("o_dac1", '0, o_dac1);
		check_gain('0, o_afe_gain);
		// bypass with random samples
		for (int j = 0; j < 40; j++) begin
			xs0[j] = $random(seed);
			xs1[j] = $random(seed);
		end
		run_stream(40);
		// new setup meets a zero sample so the filter starts from rest
		i_adc0 = '0;
		i_adc1 = '0;
		// step response with b0 = a1 = 0.5 after a few zeros
		i_cfg0.iir = '{on: 1'b1, a1: 18'sd32768, b0: 18'sd32768, b1: 18'sd0};
		i_cfg1.iir = i_cfg0.iir;
		for (int j = 0; j < 30; j++) begin
			xs0[j] = (j < 4) ? 16'sd0 : 16'sd1000;
			xs1[j] = (j < 4) ? 16'sd0 : -16'sd500;
		end
		run_stream(30);
		i_cfg0.iir = '0;
		i_cfg1.iir = '0;
		// gain fields and their read-back
		for (int g = 0; g < 4; g++) begin
			i_cfg0.gain = 2'(g);
			i_cfg1.gain = 2'(g + 1);
			cmd_addr[0] = `SERVO_ADDR_GAIN;
			cmd_adc[0] = '0;
			exp_rsp[0] = '{valid: 1'b1, err: 1'b0, data: {12'h0, 2'(g + 1), 2'(g)}};
			run_cmds(1);
			// front-end code is 3 minus the gain field
			check_gain({2'(3 - (g + 1)), 2'(3 - g)}, o_afe_gain);
		end
		// back to back reads including an unknown address
		cmd_addr[0] = `SERVO_ADDR_VERSION;
		cmd_addr[1] = `SERVO_ADDR_ADC0;
		cmd_addr[2] = `SERVO_ADDR_ADC1;
		cmd_addr[3] = 16'h0055;
		cmd_addr[4] = `SERVO_ADDR_ADC0;
		cmd_addr[5] = `SERVO_ADDR_DIFF;
		for (int k = 0; k < 6; k++)
			cmd_adc[k] = $random(seed);
		exp_rsp[0] = '{valid: 1'b1, err: 1'b0, data: `SERVO_FW_VERSION};
		exp_rsp[1] = '{valid: 1'b1, err: 1'b0, data: cmd_adc[1]};
		exp_rsp[2] = '{valid: 1'b1, err: 1'b0, data: ~cmd_adc[2]};
		exp_rsp[3] = '{valid: 1'b1, err: 1'b1, data: 16'h0};
		exp_rsp[4] = '{valid: 1'b1, err: 1'b0, data: cmd_adc[4]};
		// difference register still holds the pair driven two strobes earlier
		exp_rsp[5] = '{valid: 1'b1, err: 1'b0, data: cmd_adc[3] - ~cmd_adc[3]};
		run_cmds(6);
		step();
		if (!o_rsp.valid) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("reply still valid after the last command");
			fail_stop();
		end
	end

endmodule

// ==== filelist.f ====
+incdir+include
hdl/servo_sig_pkg.sv
hdl/servo_cmd_pkg.sv
hdl/cmd_decode.sv
hdl/iir_first_order.sv
hdl/servo_result.sv
hdl/servo_top.sv
verification/tb_clock.sv
verification/tb_servo_top.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = tb_servo_top
RTL_TOP = servo_top
FILELIST = filelist.f
PASS_MSG = PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; else exit 1; fi

clean:
	rm -rf obj_dir
